// File: hdl/rename_settings.svh
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// Logical registers seen by software
`define RN_LOGIC_NUM 8

// Physical register entries
`define RN_PHYS_NUM 16

// Reorder tags, one commit bit each
`define RN_TAG_NUM 16

// Register data width
`define RN_DATA_W 32

`endif

// File: hdl/rename_pkg.sv
`include "rename_settings.svh"

package rename_pkg;

	typedef logic [$clog2(`RN_LOGIC_NUM)-1:0] logic_name_t;
	typedef logic [$clog2(`RN_PHYS_NUM)-1:0] phys_name_t;
	typedef logic [$clog2(`RN_TAG_NUM)-1:0] commit_tag_t;
	typedef logic [`RN_TAG_NUM-1:0] commit_vec_t;

	// Rename request from decode
	typedef struct packed {
		logic valid;
		logic_name_t logic_dest;
		commit_tag_t commit_tag;
	} rename_req_t;

	// Accepted rename, broadcast to every entry
	typedef struct packed {
		logic valid;
		logic_name_t logic_dest;
		commit_tag_t commit_tag;
		phys_name_t phys_dest;
	} regist_t;

	// Execution writeback bus
	typedef struct packed {
		logic valid;
		commit_tag_t commit_tag;
		phys_name_t phys_name;
		logic [`RN_DATA_W-1:0] data;
	} exend_t;

	// Per entry status towards free list and read port
	typedef struct packed {
		logic freelist_req;
		logic data_valid;
		logic_name_t logic_dest;
		logic [`RN_DATA_W-1:0] data;
	} entry_info_t;

endpackage

// File: hdl/rename_intake.sv
`include "rename_settings.svh"

module rename_intake (
	input logic iCLOCK,
	input logic inRESET,
	input logic free_restart,
	input rename_pkg::rename_req_t rename_req_0,
	input rename_pkg::rename_req_t rename_req_1,
	input rename_pkg::phys_name_t head_name_0,
	input rename_pkg::phys_name_t head_name_1,
	input logic [$clog2(`RN_PHYS_NUM):0] free_count,
	output logic rename_ready,
	output rename_pkg::regist_t regist_0,
	output rename_pkg::regist_t regist_1,
	output logic [1:0] pop_count
);

	logic restart_hold;
	logic accept_0;
	logic accept_1;

	// Keeps intake closed on the cycle after a rollback
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			restart_hold <= 1'b0;
		end else begin
			restart_hold <= free_restart;
		end
	end

	// Two free names needed so a pair can always be served
	assign rename_ready = !free_restart && !restart_hold && (free_count >= 2);

	assign accept_0 = rename_ready && rename_req_0.valid;
	assign accept_1 = rename_ready && rename_req_1.valid;

	assign regist_0.valid = accept_0;
	assign regist_0.logic_dest = rename_req_0.logic_dest;
	assign regist_0.commit_tag = rename_req_0.commit_tag;
	assign regist_0.phys_dest = head_name_0;

	// Slot 1 moves up to the head name when slot 0 is empty
	assign regist_1.valid = accept_1;
	assign regist_1.logic_dest = rename_req_1.logic_dest;
	assign regist_1.commit_tag = rename_req_1.commit_tag;
	assign regist_1.phys_dest = accept_0 ? head_name_1 : head_name_0;

	assign pop_count = {1'b0, accept_0} + {1'b0, accept_1};

endmodule

// File: hdl/free_list.sv
`include "rename_settings.svh"

module free_list (
	input logic iCLOCK,
	input logic inRESET,
	input logic [1:0] pop_count,
	input logic [`RN_PHYS_NUM-1:0] freelist_req,
	output logic [`RN_PHYS_NUM-1:0] freelist_grant,
	output rename_pkg::phys_name_t head_name_0,
	output rename_pkg::phys_name_t head_name_1,
	output logic [$clog2(`RN_PHYS_NUM):0] free_count
);
	import rename_pkg::*;

	localparam int PTR_W = $clog2(`RN_PHYS_NUM) + 1;

	phys_name_t queue [`RN_PHYS_NUM];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	phys_name_t rd_idx_1;
	phys_name_t push_name;
	logic push;

	// Lowest index requester wins
	assign freelist_grant = freelist_req & (~freelist_req + 1'b1);
	assign push = |freelist_req;

	always_comb begin
		push_name = '0;
		for (int i = `RN_PHYS_NUM - 1; i >= 0; i--) begin
			if (freelist_req[i]) begin
				push_name = phys_name_t'(i);
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (push) begin
			queue[wr_ptr[PTR_W-2:0]] <= push_name;
		end
	end

	// Pointers keep running through a rollback
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
		end else begin
			rd_ptr <= rd_ptr + PTR_W'(pop_count);
			wr_ptr <= wr_ptr + PTR_W'(push);
		end
	end

	assign rd_idx_1 = rd_ptr[PTR_W-2:0] + 1'b1;
	assign head_name_0 = queue[rd_ptr[PTR_W-2:0]];
	assign head_name_1 = queue[rd_idx_1];
	assign free_count = wr_ptr - rd_ptr;

endmodule

// File: hdl/phys_reg_entry.sv
`include "rename_settings.svh"

module phys_reg_entry #(
	parameter int ENTRY_ID = 0
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic free_restart,
	input rename_pkg::commit_vec_t commit_vector,
	input rename_pkg::regist_t regist_0,
	input rename_pkg::regist_t regist_1,
	input rename_pkg::exend_t exend_adder,
	input rename_pkg::exend_t exend_muldiv,
	input rename_pkg::exend_t exend_ldst,
	input logic freelist_grant,
	output rename_pkg::entry_info_t info
);
	import rename_pkg::*;

	typedef enum logic [2:0] {
		st_reset_wait,
		st_reset_grant,
		st_free_grant,
		st_regist_wait,
		st_live
	} state_t;

	localparam bit IS_HOME = ENTRY_ID < `RN_LOGIC_NUM;
	localparam phys_name_t MY_NAME = phys_name_t'(ENTRY_ID);

	state_t state;
	logic freelist_req_r;
	logic_name_t logic_dest;
	logic [`RN_DATA_W-1:0] data;
	logic data_valid;
	commit_tag_t commit_tag;
	logic commit_valid;
	logic after_valid;
	commit_tag_t after_tag;
	logic after_commit;
	logic alloc_0;
	logic alloc_1;
	logic succ_0;
	logic succ_1;
	logic release_ok;

	function automatic logic wb_hit(input exend_t bus, input commit_tag_t tag);
		return bus.valid && (bus.commit_tag == tag) && (bus.phys_name == MY_NAME);
	endfunction

	assign alloc_0 = regist_0.valid && (regist_0.phys_dest == MY_NAME);
	assign alloc_1 = regist_1.valid && (regist_1.phys_dest == MY_NAME);
	// Younger rename of the same logical register
	assign succ_0 = regist_0.valid && (regist_0.logic_dest == logic_dest);
	assign succ_1 = regist_1.valid && (regist_1.logic_dest == logic_dest);
	assign release_ok = after_valid && after_commit && data_valid && commit_valid;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= st_reset_wait;
			freelist_req_r <= 1'b0;
			logic_dest <= logic_name_t'(ENTRY_ID);
			data <= '0;
			data_valid <= IS_HOME;
			commit_tag <= '0;
			commit_valid <= IS_HOME;
			after_valid <= 1'b0;
			after_tag <= '0;
			after_commit <= 1'b0;
		end else if (free_restart) begin
			// Rollback drops speculative values and successors
			if (state == st_live && !commit_valid) begin
				state <= st_free_grant;
				freelist_req_r <= 1'b1;
				data_valid <= 1'b0;
				after_valid <= 1'b0;
				after_commit <= 1'b0;
			end else if (state == st_live && !after_commit) begin
				after_valid <= 1'b0;
			end
		end else begin
			case (state)
				st_reset_wait: begin
					state <= IS_HOME ? st_live : st_reset_grant;
					freelist_req_r <= !IS_HOME;
				end
				st_reset_grant, st_free_grant: begin
					if (freelist_grant) begin
						state <= st_regist_wait;
						freelist_req_r <= 1'b0;
					end
				end
				st_regist_wait: begin
					if (alloc_0) begin
						state <= st_live;
						logic_dest <= regist_0.logic_dest;
						commit_tag <= regist_0.commit_tag;
						// Slot 1 of the same cycle may already replace us
						after_valid <= regist_1.valid &&
							(regist_1.logic_dest == regist_0.logic_dest);
						after_tag <= regist_1.commit_tag;
					end else if (alloc_1) begin
						state <= st_live;
						logic_dest <= regist_1.logic_dest;
						commit_tag <= regist_1.commit_tag;
						after_valid <= 1'b0;
					end
				end
				default: begin
					if (release_ok) begin
						state <= st_free_grant;
						freelist_req_r <= 1'b1;
						data_valid <= 1'b0;
						commit_valid <= 1'b0;
						after_valid <= 1'b0;
						after_commit <= 1'b0;
					end else begin
						if (!after_valid && succ_0) begin
							after_valid <= 1'b1;
							after_tag <= regist_0.commit_tag;
						end else if (!after_valid && succ_1) begin
							after_valid <= 1'b1;
							after_tag <= regist_1.commit_tag;
						end
						if (after_valid && commit_vector[after_tag]) begin
							after_commit <= 1'b1;
						end
						// Adder first, then muldiv, then load/store
						if (!data_valid) begin
							if (wb_hit(exend_adder, commit_tag)) begin
								data <= exend_adder.data;
								data_valid <= 1'b1;
							end else if (wb_hit(exend_muldiv, commit_tag)) begin
								data <= exend_muldiv.data;
								data_valid <= 1'b1;
							end else if (wb_hit(exend_ldst, commit_tag)) begin
								data <= exend_ldst.data;
								data_valid <= 1'b1;
							end
						end
						if (commit_vector[commit_tag]) begin
							commit_valid <= 1'b1;
						end
					end
				end
			endcase
		end
	end

	assign info.freelist_req = freelist_req_r && !free_restart;
	// Only the newest rename of a logical register is visible
	assign info.data_valid = data_valid && !after_valid;
	assign info.logic_dest = logic_dest;
	assign info.data = data;

endmodule

// File: hdl/arch_read_port.sv
`include "rename_settings.svh"

module arch_read_port (
	input rename_pkg::entry_info_t entry_info [`RN_PHYS_NUM],
	input rename_pkg::logic_name_t read_logic,
	output logic [`RN_DATA_W-1:0] read_data,
	output logic read_valid
);

	logic [`RN_PHYS_NUM-1:0] hit;

	// At most one entry per logical register reports valid data
	always_comb begin
		read_data = '0;
		for (int i = 0; i < `RN_PHYS_NUM; i++) begin
			hit[i] = entry_info[i].data_valid && (entry_info[i].logic_dest == read_logic);
			read_data = read_data | ({`RN_DATA_W{hit[i]}} & entry_info[i].data);
		end
	end

	assign read_valid = |hit;

endmodule

// File: hdl/rename_regfile_top.sv
`include "rename_settings.svh"

module rename_regfile_top (
	input logic iCLOCK,
	input logic inRESET,
	input rename_pkg::rename_req_t rename_req_0,
	input rename_pkg::rename_req_t rename_req_1,
	input rename_pkg::exend_t exend_adder,
	input rename_pkg::exend_t exend_muldiv,
	input rename_pkg::exend_t exend_ldst,
	input rename_pkg::commit_vec_t commit_vector,
	input logic free_restart,
	input rename_pkg::logic_name_t read_logic,
	output logic rename_ready,
	output rename_pkg::phys_name_t rename_phys_0,
	output rename_pkg::phys_name_t rename_phys_1,
	output logic [`RN_DATA_W-1:0] read_data,
	output logic read_valid,
	output logic [$clog2(`RN_PHYS_NUM):0] free_count
);
	import rename_pkg::*;

	regist_t regist_0;
	regist_t regist_1;
	logic [1:0] pop_count;
	phys_name_t head_name_0;
	phys_name_t head_name_1;
	logic [`RN_PHYS_NUM-1:0] freelist_req;
	logic [`RN_PHYS_NUM-1:0] freelist_grant;
	entry_info_t entry_info [`RN_PHYS_NUM];

	rename_intake u_intake (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.free_restart(free_restart),
		.rename_req_0(rename_req_0),
		.rename_req_1(rename_req_1),
		.head_name_0(head_name_0),
		.head_name_1(head_name_1),
		.free_count(free_count),
		.rename_ready(rename_ready),
		.regist_0(regist_0),
		.regist_1(regist_1),
		.pop_count(pop_count)
	);

	free_list u_free_list (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.pop_count(pop_count),
		.freelist_req(freelist_req),
		.freelist_grant(freelist_grant),
		.head_name_0(head_name_0),
		.head_name_1(head_name_1),
		.free_count(free_count)
	);

	for (genvar i = 0; i < `RN_PHYS_NUM; i++) begin : g_entry
		phys_reg_entry #(
			.ENTRY_ID(i)
		) u_entry (
			.iCLOCK(iCLOCK),
			.inRESET(inRESET),
			.free_restart(free_restart),
			.commit_vector(commit_vector),
			.regist_0(regist_0),
			.regist_1(regist_1),
			.exend_adder(exend_adder),
			.exend_muldiv(exend_muldiv),
			.exend_ldst(exend_ldst),
			.freelist_grant(freelist_grant[i]),
			.info(entry_info[i])
		);
		assign freelist_req[i] = entry_info[i].freelist_req;
	end

	arch_read_port u_read_port (
		.entry_info(entry_info),
		.read_logic(read_logic),
		.read_data(read_data),
		.read_valid(read_valid)
	);

	assign rename_phys_0 = regist_0.phys_dest;
	assign rename_phys_1 = regist_1.phys_dest;

endmodule

// File: verification/tb_rename_regfile.sv
`include "rename_settings.svh"

module tb_rename_regfile;
	timeunit 1ns;
	timeprecision 100ps;
	import rename_pkg::*;

	localparam int MAX_OPS = 64;
	localparam int WAIT_LIMIT = 40;
	localparam int SETTLE_CYCLES = 4;

	logic iCLOCK;
	logic inRESET;
	rename_req_t rename_req_0;
	rename_req_t rename_req_1;
	exend_t exend_adder;
	exend_t exend_muldiv;
	exend_t exend_ldst;
	commit_vec_t commit_vector;
	logic free_restart;
	logic_name_t read_logic;
	logic rename_ready;
	phys_name_t rename_phys_0;
	phys_name_t rename_phys_1;
	logic [`RN_DATA_W-1:0] read_data;
	logic read_valid;
	logic [$clog2(`RN_PHYS_NUM):0] free_count;

	logic [31:0] pat [0:5*MAX_OPS-1];
	phys_name_t tag_phys [`RN_TAG_NUM];
	int n_ops;
	int cycle_count;
	int cycle_limit;
	int error_count;
	int ops_passed;
	int ops_failed;

	rename_regfile_top UUT (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.rename_req_0(rename_req_0),
		.rename_req_1(rename_req_1),
		.exend_adder(exend_adder),
		.exend_muldiv(exend_muldiv),
		.exend_ldst(exend_ldst),
		.commit_vector(commit_vector),
		.free_restart(free_restart),
		.read_logic(read_logic),
		.rename_ready(rename_ready),
		.rename_phys_0(rename_phys_0),
		.rename_phys_1(rename_phys_1),
		.read_data(read_data),
		.read_valid(read_valid),
		.free_count(free_count)
	);

	always #50 iCLOCK = ~iCLOCK;

	always @(posedge iCLOCK) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, the run did not finish", cycle_count);
			$display("TESTS FAILED");
			$finish;
		end
	end

	function automatic string op_name(input logic [3:0] code);
		case (code)
			4'h1: return "rename";
			4'h2: return "writeback";
			4'h3: return "commit";
			4'h4: return "restart";
			4'h5: return "wait";
			4'h6: return "check-read";
			4'h7: return "check-free";
			4'h8: return "check-ready";
			4'h9: return "hold";
			default: return "unknown";
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("Error at %0d ns: %s expected %h actual %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	// Requests stay on the bus until rename_ready lets them in
	task automatic do_rename(input logic [1:0] mask, input logic [7:0] dests,
		input logic [7:0] tags, input logic [7:0] names);
		int waited;
		waited = 0;
		@(negedge iCLOCK);
		rename_req_0.valid = mask[0];
		rename_req_0.logic_dest = dests[6:4];
		rename_req_0.commit_tag = tags[7:4];
		rename_req_1.valid = mask[1];
		rename_req_1.logic_dest = dests[2:0];
		rename_req_1.commit_tag = tags[3:0];
		#25;
		while (!rename_ready && waited < WAIT_LIMIT) begin
			@(negedge iCLOCK);
			#25;
			waited++;
		end
		assert (rename_ready) else begin
			$display("Rename was never accepted, rename_ready stayed low");
			error_count++;
		end
		if (mask[0]) begin
			check_value("rename_phys_0", 32'(names[7:4]), 32'(rename_phys_0));
			tag_phys[tags[7:4]] = names[7:4];
		end
		if (mask[1]) begin
			check_value("rename_phys_1", 32'(names[3:0]), 32'(rename_phys_1));
			tag_phys[tags[3:0]] = names[3:0];
		end
		@(negedge iCLOCK);
		rename_req_0 = '0;
		rename_req_1 = '0;
	endtask

	task automatic do_writeback(input logic [1:0] bus, input commit_tag_t tag,
		input logic [31:0] value);
		exend_t wb;
		wb.valid = 1'b1;
		wb.commit_tag = tag;
		wb.phys_name = tag_phys[tag];
		wb.data = value;
		@(negedge iCLOCK);
		case (bus)
			2'd0: exend_adder = wb;
			2'd1: exend_muldiv = wb;
			default: exend_ldst = wb;
		endcase
		@(negedge iCLOCK);
		exend_adder = '0;
		exend_muldiv = '0;
		exend_ldst = '0;
	endtask

	task automatic do_commit(input commit_tag_t tag);
		@(negedge iCLOCK);
		commit_vector = '0;
		commit_vector[tag] = 1'b1;
		@(negedge iCLOCK);
		commit_vector = '0;
	endtask

	task automatic do_restart();
		@(negedge iCLOCK);
		free_restart = 1'b1;
		@(negedge iCLOCK);
		free_restart = 1'b0;
	endtask

	task automatic check_read(input logic_name_t lreg, input logic exp_valid,
		input logic [31:0] exp_data);
		@(negedge iCLOCK);
		read_logic = lreg;
		#25;
		check_value("read_valid", 32'(exp_valid), 32'(read_valid));
		check_value("read_data", exp_data, 32'(read_data));
	endtask

	// Free list refills one name per cycle
	task automatic check_free(input logic [31:0] expected);
		int waited;
		waited = 0;
		@(negedge iCLOCK);
		while (32'(free_count) != expected && waited < WAIT_LIMIT) begin
			@(negedge iCLOCK);
			waited++;
		end
		check_value("free_count", expected, 32'(free_count));
		// No further names may arrive once the count is reached
		repeat (SETTLE_CYCLES) begin
			@(negedge iCLOCK);
			check_value("free_count", expected, 32'(free_count));
		end
	endtask

	task automatic check_ready(input logic expected);
		@(negedge iCLOCK);
		#25;
		check_value("rename_ready", 32'(expected), 32'(rename_ready));
	endtask

	task automatic hold_request(input int cycles, input logic_name_t lreg,
		input commit_tag_t tag, input logic [31:0] count);
		@(negedge iCLOCK);
		rename_req_0.valid = 1'b1;
		rename_req_0.logic_dest = lreg;
		rename_req_0.commit_tag = tag;
		repeat (cycles) begin
			#25;
			check_value("rename_ready", 32'h0, 32'(rename_ready));
			check_value("free_count", count, 32'(free_count));
			@(negedge iCLOCK);
		end
		rename_req_0 = '0;
	endtask

	initial begin
		logic [31:0] op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		int errors_before;
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		rename_req_0 = '0;
		rename_req_1 = '0;
		exend_adder = '0;
		exend_muldiv = '0;
		exend_ldst = '0;
		commit_vector = '0;
		free_restart = 1'b0;
		read_logic = '0;
		error_count = 0;
		ops_passed = 0;
		ops_failed = 0;
		cycle_count = 0;
		n_ops = 0;
		for (int t = 0; t < `RN_TAG_NUM; t++) begin
			tag_phys[t] = '0;
		end
		$readmemh("verification/rename_patterns.txt", pat);
		while (n_ops < MAX_OPS && pat[5*n_ops] !== 32'hF) begin
			n_ops++;
		end
		cycle_limit = 40 * n_ops + 200;
		assert (n_ops > 0) else begin
			$display("Pattern file holds no operations");
			error_count++;
		end

		repeat (10) @(negedge iCLOCK);
		inRESET = 1'b1;

		for (int i = 0; i < n_ops; i++) begin
			op = pat[5*i];
			a = pat[5*i+1];
			b = pat[5*i+2];
			c = pat[5*i+3];
			d = pat[5*i+4];
			errors_before = error_count;
			case (op[3:0])
				4'h1: do_rename(a[1:0], b[7:0], c[7:0], d[7:0]);
				4'h2: do_writeback(a[1:0], b[3:0], d);
				4'h3: do_commit(a[3:0]);
				4'h4: do_restart();
				4'h5: repeat (a) @(negedge iCLOCK);
				4'h6: check_read(a[2:0], b[0], d);
				4'h7: check_free(a);
				4'h8: check_ready(a[0]);
				4'h9: hold_request(a, b[2:0], c[3:0], d);
				default: begin
					assert (1'b0) else begin
						$display("Unknown operation code %h in line %0d", op, i);
						error_count++;
					end
				end
			endcase
			if (error_count == errors_before) begin
				ops_passed++;
				$display("Op %0d %s: ok", i, op_name(op[3:0]));
			end else begin
				ops_failed++;
				$display("Op %0d %s: failed", i, op_name(op[3:0]));
			end
		end

		$display("Summary: %0d ops, %0d passed, %0d failed, %0d errors", n_ops, ops_passed,
			ops_failed, error_count);
		if (ops_failed == 0 && error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: sim.f
+incdir+hdl
hdl/rename_pkg.sv
hdl/rename_intake.sv
hdl/free_list.sv
hdl/phys_reg_entry.sv
hdl/arch_read_port.sv
hdl/rename_regfile_top.sv
verification/tb_rename_regfile.sv

// File: Makefile
TOOL       = verilator
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_rename_regfile
FILELIST   = sim.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = TESTS PASSED

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/rename_patterns.txt
// Columns: op a b c d, all hex. 1 rename: a slot mask, b dests, c tags, d expected names
// 2 writeback: a bus, b tag, d data. 3 commit: a tag. 4 restart. 5 wait: a cycles
// 6 read: a logical, b valid, d data. 7 free count: a. 8 ready: a
// 9 hold: a cycles, b logical, c tag, d free count. F end
7 8 0 0 00000000
6 0 1 0 00000000
6 1 1 0 00000000
6 2 1 0 00000000
6 3 1 0 00000000
6 4 1 0 00000000
6 5 1 0 00000000
6 6 1 0 00000000
6 7 1 0 00000000
8 1 0 0 00000000
// Logical 3 renamed, written back before commit
1 1 30 10 00000080
7 7 0 0 00000000
6 3 0 0 00000000
2 0 1 0 12345678
6 3 1 0 12345678
3 1 0 0 00000000
7 8 0 0 00000000
6 3 1 0 12345678
// Pair to logical 5 in one cycle
1 3 55 23 0000009A
7 6 0 0 00000000
2 1 2 0 AAAA0002
2 2 3 0 BBBB0003
6 5 1 0 BBBB0003
3 2 0 0 00000000
7 7 0 0 00000000
3 3 0 0 00000000
7 8 0 0 00000000
6 5 1 0 BBBB0003
// Rollback of an uncommitted rename
1 1 30 40 000000B0
6 3 0 0 00000000
2 0 4 0 DEAD0004
6 3 1 0 DEAD0004
4 0 0 0 00000000
7 8 0 0 00000000
6 3 1 0 12345678
// Drain the free list
1 3 01 56 000000CD
1 3 24 78 000000EF
1 3 67 9A 00000035
1 2 00 0B 00000009
7 1 0 0 00000000
8 0 0 0 00000000
9 5 4 C 00000001
7 1 0 0 00000000
F 0 0 0 00000000
